//--- src/uart_pkg.sv
////////////////////////////////////////////////////////////
// serial line constants and types
// frame is start bit, 8 data bits lsb first, stop bit
////////////////////////////////////////////////////////////

package uart_pkg;

   ////////////////////////////////////////////////////////////
   // sizes

   localparam int DIV_W   = 16;  // bit duration counter width
   localparam int DATA_W  = 8;   // data bits per frame
   localparam int DIV_MIN = 4;   // shortest legal bit, in cycles

   ////////////////////////////////////////////////////////////
   // types

   typedef logic [DATA_W-1:0] byte_t;
   typedef logic [DIV_W-1:0]  div_t;

   // word handed from the receiver to the register block
   typedef struct packed {
      logic  frame_err;  // stop bit sampled low
      byte_t data;
   } rx_word_t;

endpackage : uart_pkg

//--- src/uart_csr_pkg.sv
////////////////////////////////////////////////////////////
// register map, register field layouts and bus widths
////////////////////////////////////////////////////////////

package uart_csr_pkg;

   localparam int ADDR_W = 3;   // bus address width
   localparam int BUS_W  = 16;  // bus data width

   ////////////////////////////////////////////////////////////
   // register addresses

   localparam logic [ADDR_W-1:0] ADDR_CTRL   = 3'd0;
   localparam logic [ADDR_W-1:0] ADDR_DIV    = 3'd1;
   localparam logic [ADDR_W-1:0] ADDR_TXDATA = 3'd2;
   localparam logic [ADDR_W-1:0] ADDR_RXDATA = 3'd3;
   localparam logic [ADDR_W-1:0] ADDR_STATUS = 3'd4;

   typedef struct packed {
      logic rx_en;     // bit 2
      logic tx_en;     // bit 1
      logic soft_rst;  // bit 0, self clearing
   } ctrl_t;

   typedef struct packed {
      logic overrun;    // bit 3, sticky
      logic frame_err;  // bit 2, sticky
      logic rx_valid;   // bit 1
      logic tx_ready;   // bit 0
   } status_t;

endpackage : uart_csr_pkg

//--- src/uart_cfg_if.sv
////////////////////////////////////////////////////////////
// runtime configuration from the register block
// to the transmit and receive stages
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

interface uart_cfg_if;
   import uart_pkg::*;

   logic soft_rst;  // one cycle pulse
   logic tx_en;
   logic rx_en;
   div_t bit_div;   // cycles per bit

   modport src (
      output soft_rst, tx_en, rx_en, bit_div
   );

   modport snk (
      input soft_rst, tx_en, rx_en, bit_div
   );

endinterface : uart_cfg_if

//--- src/uart_csr.sv
////////////////////////////////////////////////////////////
// bus slave with CTRL, DIV, TXDATA, RXDATA and STATUS
// transmit hand-off and receive holding register
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module uart_csr (
   input  logic                           clk_i,
   input  logic                           arst_i,
   input  logic                           bus_req_i,
   input  logic                           bus_we_i,
   input  logic [uart_csr_pkg::ADDR_W-1:0] bus_addr_i,
   input  logic [uart_csr_pkg::BUS_W-1:0]  bus_wdata_i,
   output logic                           bus_ack_o,
   output logic [uart_csr_pkg::BUS_W-1:0]  bus_rdata_o,
   uart_cfg_if.src                        cfg,
   output logic                           tx_req_o,
   input  logic                           tx_ack_i,
   output uart_pkg::byte_t                tx_data_o,
   input  logic                           rx_req_i,
   output logic                           rx_ack_o,
   input  uart_pkg::rx_word_t             rx_word_i,
   output logic                           rts_o
);
   import uart_pkg::*;
   import uart_csr_pkg::*;

   ctrl_t             ctrl_q;
   div_t              div_q;
   logic              ack_q;
   logic [BUS_W-1:0]  rdata_q;
   logic              tx_req_q;
   byte_t             tx_data_q;
   logic              rx_ack_q;
   logic              rx_valid_q;
   byte_t             rx_data_q;
   logic              frame_err_q;
   logic              overrun_q;
   status_t           status;
   logic              access;
   logic              rd_rx;
   logic              tx_wr;
   logic              rx_accept;

   assign access    = bus_req_i && !ack_q;  // new cycle, not yet acked
   assign rd_rx     = access && !bus_we_i && (bus_addr_i == ADDR_RXDATA);
   assign tx_wr     = access && bus_we_i && (bus_addr_i == ADDR_TXDATA);
   assign rx_accept = rx_req_i && !rx_ack_q && (!rx_valid_q || rd_rx);

   always_comb begin
      status           = '0;
      status.tx_ready  = ctrl_q.tx_en && !tx_req_q && !tx_ack_i;
      status.rx_valid  = rx_valid_q;
      status.frame_err = frame_err_q;
      status.overrun   = overrun_q;
   end

   ////////////////////////////////////////////////////////////
   // bus decode, CTRL, DIV and transmit hand-off

   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i) begin
         ack_q    <= 1'b0;
         ctrl_q   <= '0;
         div_q    <= div_t'(DIV_MIN);
         tx_req_q <= 1'b0;
      end else begin
         ctrl_q.soft_rst <= 1'b0;  // pulse only
         if (!bus_req_i) begin
            ack_q <= 1'b0;
         end else if (!ack_q) begin
            if (bus_we_i && bus_addr_i == ADDR_CTRL) begin
               ctrl_q <= ctrl_t'(bus_wdata_i[$bits(ctrl_t)-1:0]);
               ack_q  <= 1'b1;
            end else if (bus_we_i && bus_addr_i == ADDR_DIV) begin
               if (bus_wdata_i < DIV_MIN)
                  div_q <= div_t'(DIV_MIN);  // clamp short bits
               else
                  div_q <= bus_wdata_i;
               ack_q <= 1'b1;
            end else if (bus_we_i && bus_addr_i == ADDR_TXDATA) begin
               if (tx_req_q && tx_ack_i) begin  // byte taken, release bus
                  tx_req_q <= 1'b0;
                  ack_q    <= 1'b1;
               end else if (!tx_req_q && !tx_ack_i) begin
                  tx_req_q <= 1'b1;
               end
            end else begin
               ack_q <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (tx_wr && !tx_req_q)
         tx_data_q <= bus_wdata_i[DATA_W-1:0];  // held while req is up
   end

   always_ff @(posedge clk_i) begin
      if (access && !bus_we_i) begin
         case (bus_addr_i)
            ADDR_CTRL:   rdata_q <= BUS_W'(ctrl_q);
            ADDR_DIV:    rdata_q <= div_q;
            ADDR_RXDATA: rdata_q <= rx_valid_q ? BUS_W'(rx_data_q) : '0;
            ADDR_STATUS: rdata_q <= BUS_W'(status);
            default:     rdata_q <= '0;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // receive holding register

   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i) begin
         rx_ack_q    <= 1'b0;
         rx_valid_q  <= 1'b0;
         frame_err_q <= 1'b0;
         overrun_q   <= 1'b0;
      end else begin
         rx_ack_q <= rx_req_i;  // always take the word
         if (ctrl_q.soft_rst) begin
            rx_valid_q  <= 1'b0;
            frame_err_q <= 1'b0;
            overrun_q   <= 1'b0;
         end else begin
            if (rd_rx)
               rx_valid_q <= 1'b0;
            if (rx_accept) begin
               rx_valid_q  <= 1'b1;
               frame_err_q <= frame_err_q | rx_word_i.frame_err;
            end else if (rx_req_i && !rx_ack_q) begin
               overrun_q <= 1'b1;  // new word dropped
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (rx_accept)
         rx_data_q <= rx_word_i.data;
   end

   assign bus_ack_o    = ack_q;
   assign bus_rdata_o  = rdata_q;
   assign tx_req_o     = tx_req_q;
   assign tx_data_o    = tx_data_q;
   assign rx_ack_o     = rx_ack_q;
   assign rts_o        = ctrl_q.rx_en && !rx_valid_q;  // room for one byte
   assign cfg.soft_rst = ctrl_q.soft_rst;
   assign cfg.tx_en    = ctrl_q.tx_en;
   assign cfg.rx_en    = ctrl_q.rx_en;
   assign cfg.bit_div  = div_q;

   // master keeps req up until it has seen ack
   a_ack_needs_req : assert property (@(posedge clk_i) disable iff (!arst_i)
      $rose(bus_ack_o) |-> bus_req_i);

   a_div_legal : assert property (@(posedge clk_i) disable iff (!arst_i)
      (bus_req_i && bus_we_i && bus_addr_i == ADDR_DIV) |-> bus_wdata_i >= BUS_W'(DIV_MIN));

endmodule : uart_csr

//--- src/uart_tx_serializer.sv
////////////////////////////////////////////////////////////
// cts synchronizer and transmit frame shifter
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module uart_tx_serializer (
   input  logic            clk_i,
   input  logic            arst_i,
   uart_cfg_if.snk         cfg,
   input  logic            tx_req_i,
   output logic            tx_ack_o,
   input  uart_pkg::byte_t tx_data_i,
   input  logic            cts_i,
   output logic            txd_o
);
   import uart_pkg::*;

   logic [1:0]        cts_sync_q;
   logic              busy_q;
   logic              ack_q;
   logic [DATA_W+1:0] shift_q;  // {stop, data, start}
   div_t              cyc_q;
   logic [3:0]        bit_q;
   logic              start;

   // idle, enabled, clear to send and a fresh request
   assign start = !busy_q && !ack_q && tx_req_i && cfg.tx_en && cts_sync_q[1];

   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i)
         cts_sync_q <= 2'b00;
      else
         cts_sync_q <= {cts_sync_q[0], cts_i};
   end

   ////////////////////////////////////////////////////////////
   // frame shifter

   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i) begin
         busy_q  <= 1'b0;
         ack_q   <= 1'b0;
         shift_q <= '1;
         cyc_q   <= '0;
         bit_q   <= '0;
      end else if (cfg.soft_rst) begin
         busy_q  <= 1'b0;
         ack_q   <= 1'b0;
         shift_q <= '1;
         cyc_q   <= '0;
         bit_q   <= '0;
      end else begin
         if (!tx_req_i)
            ack_q <= 1'b0;  // four-phase return
         if (start) begin
            shift_q <= {1'b1, tx_data_i, 1'b0};
            busy_q  <= 1'b1;
            ack_q   <= 1'b1;
            cyc_q   <= div_t'(1);
            bit_q   <= '0;
         end else if (busy_q) begin
            if (cyc_q == cfg.bit_div) begin
               cyc_q <= div_t'(1);
               if (bit_q == 4'(DATA_W + 1)) begin  // stop bit done
                  busy_q <= 1'b0;
               end else begin
                  shift_q <= {1'b1, shift_q[DATA_W+1:1]};
                  bit_q   <= bit_q + 4'd1;
               end
            end else begin
               cyc_q <= cyc_q + 1'b1;
            end
         end
      end
   end

   assign tx_ack_o = ack_q;
   assign txd_o    = shift_q[0];

   // shifter is back to all ones once the stop bit is out
   a_idle_line_high : assert property (@(posedge clk_i) disable iff (!arst_i)
      !busy_q |-> txd_o);

endmodule : uart_tx_serializer

//--- src/uart_rx_deserializer.sv
////////////////////////////////////////////////////////////
// rxd synchronizer, start detection, mid-bit sampling
// stop check and four-phase word hand-off
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module uart_rx_deserializer (
   input  logic               clk_i,
   input  logic               arst_i,
   uart_cfg_if.snk            cfg,
   input  logic               rxd_i,
   output logic               rx_req_o,
   input  logic               rx_ack_i,
   output uart_pkg::rx_word_t rx_word_o
);
   import uart_pkg::*;

   typedef enum logic [2:0] {
      S_SYNC,   // line must stay high for one bit
      S_IDLE,   // waiting for the start edge
      S_START,  // half bit into the start bit
      S_DATA,
      S_STOP
   } state_t;

   logic [1:0]                rxd_sync_q;
   logic                      rxd_s;
   state_t                    state_q;
   div_t                      cyc_q;
   logic [$clog2(DATA_W)-1:0] bit_q;
   byte_t                     shift_q;
   logic                      req_q;
   rx_word_t                  word_q;
   logic                      bit_end;
   logic                      done;

   assign rxd_s   = rxd_sync_q[1];
   assign bit_end = (cyc_q == cfg.bit_div);
   assign done    = (state_q == S_STOP) && bit_end;  // middle of stop bit

   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i)
         rxd_sync_q <= 2'b11;  // idle line level
      else
         rxd_sync_q <= {rxd_sync_q[0], rxd_i};
   end

   ////////////////////////////////////////////////////////////
   // frame FSM

   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i) begin
         state_q <= S_SYNC;
         cyc_q   <= div_t'(1);
         bit_q   <= '0;
      end else if (cfg.soft_rst || !cfg.rx_en) begin
         state_q <= S_SYNC;
         cyc_q   <= div_t'(1);
         bit_q   <= '0;
      end else begin
         case (state_q)
            S_SYNC: begin
               if (!rxd_s)
                  cyc_q <= div_t'(1);  // line low, start over
               else if (bit_end)
                  state_q <= S_IDLE;
               else
                  cyc_q <= cyc_q + 1'b1;
            end
            S_IDLE: begin
               cyc_q <= div_t'(1);
               if (!rxd_s)
                  state_q <= S_START;
            end
            S_START: begin
               if (cyc_q == (cfg.bit_div >> 1)) begin
                  cyc_q   <= div_t'(1);
                  bit_q   <= '0;
                  state_q <= rxd_s ? S_SYNC : S_DATA;  // glitch, drop it
               end else begin
                  cyc_q <= cyc_q + 1'b1;
               end
            end
            S_DATA: begin
               if (bit_end) begin
                  cyc_q <= div_t'(1);
                  if (int'(bit_q) == DATA_W - 1)
                     state_q <= S_STOP;
                  else
                     bit_q <= bit_q + 1'b1;
               end else begin
                  cyc_q <= cyc_q + 1'b1;
               end
            end
            S_STOP: begin
               if (bit_end) begin
                  cyc_q   <= div_t'(1);
                  state_q <= rxd_s ? S_IDLE : S_SYNC;  // bad stop, resync
               end else begin
                  cyc_q <= cyc_q + 1'b1;
               end
            end
            default: state_q <= S_SYNC;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == S_DATA && bit_end)
         shift_q <= {rxd_s, shift_q[DATA_W-1:1]};  // lsb arrives first
   end

   ////////////////////////////////////////////////////////////
   // word hand-off

   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i)
         req_q <= 1'b0;
      else if (cfg.soft_rst || !cfg.rx_en)
         req_q <= 1'b0;
      else if (rx_ack_i)
         req_q <= 1'b0;
      else if (done)
         req_q <= 1'b1;
   end

   always_ff @(posedge clk_i) begin
      if (done) begin
         word_q.data      <= shift_q;
         word_q.frame_err <= !rxd_s;
      end
   end

   assign rx_req_o  = req_q;
   assign rx_word_o = word_q;

endmodule : uart_rx_deserializer

//--- src/uart_top.sv
////////////////////////////////////////////////////////////
// UART top level, register block and both serial stages
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module uart_top (
   input  logic                            clk_i,
   input  logic                            arst_i,
   input  logic                            bus_req_i,
   input  logic                            bus_we_i,
   input  logic [uart_csr_pkg::ADDR_W-1:0] bus_addr_i,
   input  logic [uart_csr_pkg::BUS_W-1:0]  bus_wdata_i,
   output logic                            bus_ack_o,
   output logic [uart_csr_pkg::BUS_W-1:0]  bus_rdata_o,
   input  logic                            rxd_i,
   output logic                            txd_o,
   input  logic                            cts_i,
   output logic                            rts_o
);
   import uart_pkg::*;

   logic     tx_req;   // csr to serializer
   logic     tx_ack;
   byte_t    tx_data;
   logic     rx_req;   // deserializer to csr
   logic     rx_ack;
   rx_word_t rx_word;

   uart_cfg_if uart_cfg_if_inst ();

   uart_csr uart_csr_inst (
      .clk_i      (clk_i),
      .arst_i     (arst_i),
      .bus_req_i  (bus_req_i),
      .bus_we_i   (bus_we_i),
      .bus_addr_i (bus_addr_i),
      .bus_wdata_i(bus_wdata_i),
      .bus_ack_o  (bus_ack_o),
      .bus_rdata_o(bus_rdata_o),
      .cfg        (uart_cfg_if_inst.src),
      .tx_req_o   (tx_req),
      .tx_ack_i   (tx_ack),
      .tx_data_o  (tx_data),
      .rx_req_i   (rx_req),
      .rx_ack_o   (rx_ack),
      .rx_word_i  (rx_word),
      .rts_o      (rts_o)
   );

   uart_tx_serializer uart_tx_serializer_inst (
      .clk_i    (clk_i),
      .arst_i   (arst_i),
      .cfg      (uart_cfg_if_inst.snk),
      .tx_req_i (tx_req),
      .tx_ack_o (tx_ack),
      .tx_data_i(tx_data),
      .cts_i    (cts_i),
      .txd_o    (txd_o)
   );

   uart_rx_deserializer uart_rx_deserializer_inst (
      .clk_i    (clk_i),
      .arst_i   (arst_i),
      .cfg      (uart_cfg_if_inst.snk),
      .rxd_i    (rxd_i),
      .rx_req_o (rx_req),
      .rx_ack_i (rx_ack),
      .rx_word_o(rx_word)
   );

endmodule : uart_top

//--- tb/tb_uart_top.sv
////////////////////////////////////////////////////////////
// testbench for the UART top level: bus tasks, serial line
// driver and monitor, frame reference, compare tasks, watchdog
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_uart_top;
   import uart_pkg::*;
   import uart_csr_pkg::*;

   localparam int    DIV             = 8;   // cycles per bit
   localparam int    CLK_PERIOD      = 20;  // ns
   localparam int    N_TESTS         = 6;
   localparam int    FRAMES_PER_TEST = 4;
   localparam int    WATCHDOG_NS     = 2 * N_TESTS * FRAMES_PER_TEST * 10 * DIV * CLK_PERIOD;
   localparam int    START_LIMIT     = 8 * DIV;  // cycles to wait for a start bit
   localparam int    POLL_LIMIT      = 4 * DIV;  // STATUS reads before giving up

   logic              clk_i;
   logic              arst_i;
   logic              bus_req_i;
   logic              bus_we_i;
   logic [ADDR_W-1:0] bus_addr_i;
   logic [BUS_W-1:0]  bus_wdata_i;
   logic              bus_ack_o;
   logic [BUS_W-1:0]  bus_rdata_o;
   logic              rxd_i;
   logic              txd_o;
   logic              cts_i;
   logic              rts_o;

   integer            seed;
   int                errors;
   int                errors_at_start;
   int                tests_run;
   int                tests_failed;
   byte_t             b;
   byte_t             b2;
   logic [9:0]        got_f;
   status_t           st;
   logic [BUS_W-1:0]  d;
   logic              held_ok;

   uart_top uart_top_inst (
      .clk_i      (clk_i),
      .arst_i     (arst_i),
      .bus_req_i  (bus_req_i),
      .bus_we_i   (bus_we_i),
      .bus_addr_i (bus_addr_i),
      .bus_wdata_i(bus_wdata_i),
      .bus_ack_o  (bus_ack_o),
      .bus_rdata_o(bus_rdata_o),
      .rxd_i      (rxd_i),
      .txd_o      (txd_o),
      .cts_i      (cts_i),
      .rts_o      (rts_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
      $display("Some tests failed");
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // reference and compare

   // start bit low, data lsb first, stop bit high
   function automatic logic [9:0] frame_bits(input byte_t data);
      logic [9:0] f;
      f[0] = 1'b0;
      for (int i = 0; i < DATA_W; i++)
         f[i + 1] = data[i];
      f[9] = 1'b1;
      return f;
   endfunction

   function automatic status_t make_status(input logic txr, input logic rxv,
                                           input logic fe, input logic ov);
      status_t s;
      s.tx_ready  = txr;
      s.rx_valid  = rxv;
      s.frame_err = fe;
      s.overrun   = ov;
      return s;
   endfunction

   task automatic check_byte(input string what, input byte_t got, input byte_t exp);
      if (got !== exp) begin
         $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic check_status(input string what, input status_t got, input status_t exp);
      if (got !== exp) begin
         $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic check_bit(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic check_frame(input logic [9:0] got, input byte_t data);
      logic [9:0] exp;
      exp = frame_bits(data);
      check_bit("tx start bit", got[0], exp[0]);
      check_byte("tx data bits", got[8:1], exp[8:1]);
      check_bit("tx stop bit", got[9], exp[9]);
   endtask

   ////////////////////////////////////////////////////////////
   // bus master, four-phase

   task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [BUS_W-1:0] data);
      @(posedge clk_i);
      bus_req_i   <= 1'b1;
      bus_we_i    <= 1'b1;
      bus_addr_i  <= addr;
      bus_wdata_i <= data;
      do @(posedge clk_i); while (bus_ack_o !== 1'b1);
      bus_req_i <= 1'b0;
      do @(posedge clk_i); while (bus_ack_o !== 1'b0);
   endtask

   task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [BUS_W-1:0] data);
      @(posedge clk_i);
      bus_req_i  <= 1'b1;
      bus_we_i   <= 1'b0;
      bus_addr_i <= addr;
      do @(posedge clk_i); while (bus_ack_o !== 1'b1);
      data = bus_rdata_o;  // valid with ack
      bus_req_i <= 1'b0;
      do @(posedge clk_i); while (bus_ack_o !== 1'b0);
   endtask

   task automatic read_status(output status_t s);
      logic [BUS_W-1:0] r;
      bus_read(ADDR_STATUS, r);
      s = status_t'(r[$bits(status_t)-1:0]);
   endtask

   // poll STATUS until every bit of mask is set
   task automatic wait_status(input status_t mask, output status_t s);
      int n;
      n = 0;
      read_status(s);
      while (((s & mask) != mask) && n < POLL_LIMIT) begin
         read_status(s);
         n++;
      end
      if ((s & mask) != mask) begin
         $display("STATUS bits %b never rose at %0t ns", mask, $time);
         errors++;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // serial line driver and monitor

   task automatic line_send(input byte_t data, input logic stop_level);
      logic [9:0] line_bits;
      line_bits    = frame_bits(data);
      line_bits[9] = stop_level;
      for (int i = 0; i < 10; i++) begin
         @(posedge clk_i);
         rxd_i <= line_bits[i];
         repeat (DIV - 1) @(posedge clk_i);
      end
      @(posedge clk_i);
      rxd_i <= 1'b1;
      repeat (DIV) @(posedge clk_i);  // idle gap
   endtask

   task automatic line_monitor(output logic [9:0] line_bits);
      logic samples [0:10*DIV-1];
      logic level;
      logic timing_ok;
      int   n;
      line_bits = '1;
      timing_ok = 1'b1;
      n         = 0;
      do begin
         @(posedge clk_i);
         level = txd_o;
         n++;
      end while (level !== 1'b0 && n < START_LIMIT);
      if (level !== 1'b0) begin
         $display("no start bit on txd_o within %0d cycles at %0t ns", START_LIMIT, $time);
         errors++;
         return;
      end
      samples[0] = level;
      for (int i = 1; i < 10 * DIV; i++) begin
         @(posedge clk_i);
         samples[i] = txd_o;
      end
      for (int k = 0; k < 10; k++) begin
         line_bits[k] = samples[k * DIV + DIV / 2];  // middle of the bit
         for (int j = 1; j < DIV - 1; j++)
            if (samples[k * DIV + j] !== line_bits[k])
               timing_ok = 1'b0;
      end
      if (!timing_ok) begin
         $display("txd_o bit length off by more than one cycle at %0t ns", $time);
         errors++;
      end
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors == errors_at_start) begin
         $display("test %0d %s: pass", tests_run, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: FAIL", tests_run, name);
      end
      errors_at_start = errors;
   endtask

   ////////////////////////////////////////////////////////////
   // test sequence

   initial begin
      seed            = 32'ha2d5_77f3;
      errors          = 0;
      errors_at_start = 0;
      tests_run       = 0;
      tests_failed    = 0;
      arst_i      <= 1'b0;
      bus_req_i   <= 1'b0;
      bus_we_i    <= 1'b0;
      bus_addr_i  <= '0;
      bus_wdata_i <= '0;
      rxd_i       <= 1'b1;
      cts_i       <= 1'b1;
      repeat (2) @(posedge clk_i);
      arst_i <= 1'b1;
      repeat (2) @(posedge clk_i);

      check_bit("txd_o after reset", txd_o, 1'b1);
      check_bit("rts_o after reset", rts_o, 1'b0);
      read_status(st);
      check_status("STATUS after reset", st, make_status(1'b0, 1'b0, 1'b0, 1'b0));
      end_test("reset state");

      bus_write(ADDR_DIV, BUS_W'(DIV));
      bus_write(ADDR_CTRL, 16'h0006);  // tx and rx on
      repeat (2 * DIV) @(posedge clk_i);  // receiver sees idle line
      for (int n = 0; n < 2; n++) begin
         b = byte_t'($random(seed));
         fork
            bus_write(ADDR_TXDATA, BUS_W'(b));
            line_monitor(got_f);
         join
         check_frame(got_f, b);
      end
      end_test("transmit");

      check_bit("rts_o with nothing held", rts_o, 1'b1);
      b = byte_t'($random(seed));
      line_send(b, 1'b1);
      wait_status(make_status(1'b0, 1'b1, 1'b0, 1'b0), st);
      check_status("STATUS after a frame", st, make_status(1'b1, 1'b1, 1'b0, 1'b0));
      check_bit("rts_o while a byte is held", rts_o, 1'b0);
      bus_read(ADDR_RXDATA, d);
      check_byte("RXDATA", byte_t'(d[DATA_W-1:0]), b);
      read_status(st);
      check_status("STATUS after RXDATA read", st, make_status(1'b1, 1'b0, 1'b0, 1'b0));
      check_bit("rts_o after RXDATA read", rts_o, 1'b1);
      end_test("receive");

      b = byte_t'($random(seed));
      line_send(b, 1'b0);  // low stop bit
      wait_status(make_status(1'b0, 1'b1, 1'b0, 1'b0), st);
      check_status("STATUS after bad stop bit", st, make_status(1'b1, 1'b1, 1'b1, 1'b0));
      bus_read(ADDR_RXDATA, d);
      repeat (2 * DIV) @(posedge clk_i);
      end_test("frame error");

      @(posedge clk_i);
      cts_i   <= 1'b0;
      held_ok  = 1'b1;
      repeat (4) @(posedge clk_i);  // through the synchronizer
      b = byte_t'($random(seed));
      fork
         bus_write(ADDR_TXDATA, BUS_W'(b));
         begin
            repeat (4 * DIV) begin
               @(posedge clk_i);
               if (held_ok && (txd_o !== 1'b1 || bus_ack_o !== 1'b0)) begin
                  $display("txd_o or bus_ack_o moved while cts_i was low at %0t ns",
                           $time);
                  errors++;
                  held_ok = 1'b0;
               end
            end
            cts_i <= 1'b1;
            line_monitor(got_f);
         end
      join
      check_frame(got_f, b);
      end_test("flow control");

      b  = byte_t'($random(seed));
      b2 = byte_t'($random(seed));
      if (b2 == b)
         b2 = ~b;
      line_send(b, 1'b1);
      line_send(b2, 1'b1);  // no read in between
      wait_status(make_status(1'b0, 1'b0, 1'b0, 1'b1), st);
      // frame error is still sticky from the bad stop bit
      check_status("STATUS after overrun", st, make_status(1'b1, 1'b1, 1'b1, 1'b1));
      bus_read(ADDR_RXDATA, d);
      check_byte("RXDATA after overrun", byte_t'(d[DATA_W-1:0]), b);
      bus_write(ADDR_CTRL, 16'h0007);  // soft reset, tx and rx stay on
      read_status(st);
      check_status("STATUS after soft reset", st, make_status(1'b1, 1'b0, 1'b0, 1'b0));
      end_test("overrun and soft reset");

      $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
               errors);
      if (errors == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule : tb_uart_top

//--- src.f
src/uart_pkg.sv
src/uart_csr_pkg.sv
src/uart_cfg_if.sv
src/uart_csr.sv
src/uart_tx_serializer.sv
src/uart_rx_deserializer.sv
src/uart_top.sv
tb/tb_uart_top.sv

//--- Makefile
# Verilator build and run for the UART testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_uart_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Some tests failed
PASS_MSG  ?= All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
